//--- verilog/rtc_map_pkg.sv
package rtc_map_pkg;

  // editable time fields starting with seconds
  localparam int NUM_FIELDS = 8;

  typedef logic [2:0] field_idx_t; // cursor over the fields
  typedef logic [7:0] reg_addr_t;
  typedef logic [7:0] reg_data_t;

  localparam reg_addr_t FIELD_BASE_ADDR = 8'h21; // field k sits at 0x21 + k

  localparam reg_addr_t CTRL_ADDR     = 8'h02;
  localparam reg_data_t CTRL_INIT_VAL = 8'h10; // first control write
  localparam reg_data_t CTRL_RUN_VAL  = 8'h00; // second control write

  // element k is the readback byte of field k
  typedef reg_data_t [NUM_FIELDS-1:0] field_bytes_t;

endpackage

//--- verilog/panel_bus_pkg.sv
package panel_bus_pkg;

  // button levels or single-cycle press pulses
  typedef struct packed {
    logic up;
    logic down;
    logic left;
    logic right;
  } buttons_t;

  // one register write towards the clock chip
  typedef struct packed {
    rtc_map_pkg::reg_addr_t addr;
    rtc_map_pkg::reg_data_t data;
  } wr_cmd_t;

endpackage

//--- verilog/button_pulse.sv
`timescale 1ns/1ps

module button_pulse (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  panel_bus_pkg::buttons_t btn_i,
  output panel_bus_pkg::buttons_t press_o
);

  panel_bus_pkg::buttons_t btn_q;
  panel_bus_pkg::buttons_t rise;

  assign rise = btn_i & ~btn_q; // low to high since last edge

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      btn_q   <= '0;
      press_o <= '0;
    end
    else
    begin
      btn_q         <= btn_i;
      press_o.up    <= rise.up & ~rise.down; // opposing presses cancel
      press_o.down  <= rise.down & ~rise.up;
      press_o.left  <= rise.left & ~rise.right;
      press_o.right <= rise.right & ~rise.left;
    end
  end

endmodule

//--- verilog/init_sequencer.sv
`timescale 1ns/1ps

module init_sequencer #(
  parameter int INIT_HOLD = 74
) (
  input  logic                   clk,
  input  logic                   rst_n_i,
  output logic                   req_o,
  output panel_bus_pkg::wr_cmd_t cmd_o,
  input  logic                   ack_i,
  output logic                   done_o
);

  localparam int CNT_W = (INIT_HOLD > 1) ? $clog2(INIT_HOLD) : 1;

  typedef enum logic [2:0] {
    ST_START,
    ST_WR1,
    ST_HOLD,
    ST_WR2,
    ST_DONE
  } state_e;

  state_e           state;
  logic [CNT_W-1:0] hold_cnt;
  logic             xfer_end; // ack has fallen after req was dropped

  assign xfer_end   = !req_o && !ack_i;
  assign cmd_o.addr = rtc_map_pkg::CTRL_ADDR;
  assign cmd_o.data = (state == ST_WR2) ? rtc_map_pkg::CTRL_RUN_VAL
                                        : rtc_map_pkg::CTRL_INIT_VAL;

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      state    <= ST_START;
      req_o    <= 1'b0;
      done_o   <= 1'b0;
      hold_cnt <= '0;
    end
    else
    begin
      case (state)
        ST_START:
        begin
          req_o <= 1'b1;
          state <= ST_WR1;
        end
        ST_WR1, ST_WR2:
        begin
          if (req_o && ack_i)
            req_o <= 1'b0;
          else if (xfer_end)
          begin
            hold_cnt <= '0;
            done_o   <= (state == ST_WR2);
            state    <= (state == ST_WR2) ? ST_DONE : ST_HOLD;
          end
        end
        ST_HOLD:
        begin
          hold_cnt <= hold_cnt + 1'b1;
          if (hold_cnt == CNT_W'(INIT_HOLD - 1))
          begin
            req_o <= 1'b1; // control register back to run
            state <= ST_WR2;
          end
        end
        default: state <= ST_DONE; // stays here until reset
      endcase
    end
  end

  // no further control writes once the chip is running
  assert property (@(posedge clk) disable iff (!rst_n_i) done_o |-> !$rose(req_o));

endmodule

//--- verilog/field_editor.sv
`timescale 1ns/1ps

module field_editor (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic                      enable_i,
  input  panel_bus_pkg::buttons_t   press_i,
  input  rtc_map_pkg::field_bytes_t fields_i,
  output logic                      req_o,
  output panel_bus_pkg::wr_cmd_t    cmd_o,
  input  logic                      ack_i
);

  localparam rtc_map_pkg::field_idx_t LAST_FIELD =
    rtc_map_pkg::field_idx_t'(rtc_map_pkg::NUM_FIELDS - 1);

  rtc_map_pkg::field_idx_t cursor;
  rtc_map_pkg::reg_data_t  cur_byte;
  logic                    pending; // from req rise until ack falls
  logic                    idle;
  logic                    start;

  assign cur_byte = fields_i[cursor];
  assign idle     = enable_i && !pending;
  assign start    = idle && (press_i.up || press_i.down);

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
      cursor <= '0;
    else if (idle && press_i.right)
    begin
      if (cursor == LAST_FIELD)
        cursor <= '0;
      else
        cursor <= cursor + 1'b1;
    end
    else if (idle && press_i.left)
    begin
      if (cursor == '0)
        cursor <= LAST_FIELD;
      else
        cursor <= cursor - 1'b1;
    end
  end

  // requester side of the four-phase link
  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      req_o   <= 1'b0;
      pending <= 1'b0;
    end
    else if (start)
    begin
      req_o   <= 1'b1;
      pending <= 1'b1;
    end
    else if (pending)
    begin
      if (req_o && ack_i)
        req_o <= 1'b0;
      else if (!req_o && !ack_i)
        pending <= 1'b0;
    end
  end

  // held from req rise until ack falls, since start needs !pending
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      cmd_o.addr <= rtc_map_pkg::FIELD_BASE_ADDR + rtc_map_pkg::reg_addr_t'(cursor);
      cmd_o.data <= press_i.up ? cur_byte + 8'd1 : cur_byte - 8'd1; // wraps mod 256
    end
  end

  // the link is never abandoned before the arbiter answered
  assert property (@(posedge clk) disable iff (!rst_n_i)
    $fell(req_o) && $past(rst_n_i) |-> $past(ack_i));

endmodule

//--- verilog/write_arbiter.sv
`timescale 1ns/1ps

module write_arbiter (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   init_req_i,
  input  panel_bus_pkg::wr_cmd_t init_cmd_i,
  output logic                   init_ack_o,
  input  logic                   edit_req_i,
  input  panel_bus_pkg::wr_cmd_t edit_cmd_i,
  output logic                   edit_ack_o,
  output logic                   bus_req_o,
  output panel_bus_pkg::wr_cmd_t bus_cmd_o,
  input  logic                   bus_ack_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUS_ACK,  // bus_req_o high, waiting for the chip
    ST_BUS_REL,  // waiting for bus_ack_i to fall
    ST_LINK_ACK  // requester acked, waiting for its req to fall
  } state_e;

  state_e state;
  logic   gnt_edit; // editor holds the grant
  logic   gnt_req;

  assign gnt_req = gnt_edit ? edit_req_i : init_req_i;

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      state      <= ST_IDLE;
      gnt_edit   <= 1'b0;
      bus_req_o  <= 1'b0;
      init_ack_o <= 1'b0;
      edit_ack_o <= 1'b0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (init_req_i || edit_req_i)
          begin
            gnt_edit  <= !init_req_i; // init wins a tie
            bus_req_o <= 1'b1;
            state     <= ST_BUS_ACK;
          end
        end
        ST_BUS_ACK:
        begin
          if (bus_ack_i)
          begin
            bus_req_o <= 1'b0;
            state     <= ST_BUS_REL;
          end
        end
        ST_BUS_REL:
        begin
          if (!bus_ack_i)
          begin
            init_ack_o <= !gnt_edit;
            edit_ack_o <= gnt_edit;
            state      <= ST_LINK_ACK;
          end
        end
        default:
        begin
          if (!gnt_req)
          begin
            init_ack_o <= 1'b0;
            edit_ack_o <= 1'b0;
            state      <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // follows the winner while idle, frozen once the bus request is out
  always_ff @(posedge clk)
  begin
    if (state == ST_IDLE)
      bus_cmd_o <= init_req_i ? init_cmd_i : edit_cmd_i;
  end

  assert property (@(posedge clk) disable iff (!rst_n_i)
    bus_req_o && $past(bus_req_o) |-> $stable(bus_cmd_o));

  // one write in flight, so only one requester is ever acked
  assert property (@(posedge clk) disable iff (!rst_n_i)
    !(init_ack_o && edit_ack_o));

endmodule

//--- verilog/rtc_setter_top.sv
`timescale 1ns/1ps

module rtc_setter_top #(
  parameter int INIT_HOLD = 74
) (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  panel_bus_pkg::buttons_t   btn_i,
  input  rtc_map_pkg::field_bytes_t fields_i,
  output logic                      bus_req_o,
  output panel_bus_pkg::wr_cmd_t    bus_cmd_o,
  input  logic                      bus_ack_i,
  output logic                      init_done_o
);

  panel_bus_pkg::buttons_t press;
  panel_bus_pkg::wr_cmd_t  init_cmd;
  panel_bus_pkg::wr_cmd_t  edit_cmd;
  logic                    init_req;
  logic                    init_ack;
  logic                    edit_req;
  logic                    edit_ack;

  button_pulse u_pulse (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .btn_i   (btn_i),
    .press_o (press)
  );

  init_sequencer #(
    .INIT_HOLD (INIT_HOLD)
  ) u_init (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .req_o   (init_req),
    .cmd_o   (init_cmd),
    .ack_i   (init_ack),
    .done_o  (init_done_o)
  );

  field_editor u_edit (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .enable_i (init_done_o), // editing starts once the chip runs
    .press_i  (press),
    .fields_i (fields_i),
    .req_o    (edit_req),
    .cmd_o    (edit_cmd),
    .ack_i    (edit_ack)
  );

  write_arbiter u_arb (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .init_req_i (init_req),
    .init_cmd_i (init_cmd),
    .init_ack_o (init_ack),
    .edit_req_i (edit_req),
    .edit_cmd_i (edit_cmd),
    .edit_ack_o (edit_ack),
    .bus_req_o  (bus_req_o),
    .bus_cmd_o  (bus_cmd_o),
    .bus_ack_i  (bus_ack_i)
  );

endmodule

//--- test/tb_bus_model.svh
`ifndef TB_BUS_MODEL_SVH
`define TB_BUS_MODEL_SVH

integer                 seed = 32'h2c5b_52a5;
int                     slow_extra = 0; // added to every ack delay while set
panel_bus_pkg::wr_cmd_t wr_log[$];      // writes in the order the chip accepted them

function automatic int ack_delay();
  return int'($unsigned($random(seed)) % 6); // 0 to 5 cycles
endfunction

task automatic report_mismatch(string name, string got, string exp);
  $display("FAIL %0t %s got %s expected %s", $time, name, got, exp);
  $display("CHECKS FAILED");
  $fatal(1, "value mismatch");
endtask

task automatic check_cmd(string name, panel_bus_pkg::wr_cmd_t got,
                         panel_bus_pkg::wr_cmd_t exp);
  if (got !== exp)
    report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
endtask

task automatic check_bit(string name, logic got, logic exp);
  if (got !== exp)
    report_mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
endtask

task automatic check_count(string name, int got, int exp);
  if (got != exp)
    report_mismatch(name, $sformatf("%0d", got), $sformatf("%0d", exp));
endtask

// chip side of the four-phase write bus
initial
begin : chip_responder
  panel_bus_pkg::wr_cmd_t held_cmd;
  bus_ack_i = 1'b0;
  forever
  begin
    step();
    if (bus_req_o === 1'b1)
    begin
      held_cmd = bus_cmd_o;
      repeat (ack_delay() + slow_extra) step();
      if (bus_req_o === 1'b1) // a reset can withdraw the request
      begin
        check_cmd("bus_cmd_o", bus_cmd_o, held_cmd);
        bus_ack_i = 1'b1;
        wr_log.push_back(bus_cmd_o);
        while (bus_req_o === 1'b1)
          step();
        repeat (ack_delay()) step();
        bus_ack_i = 1'b0;
      end
    end
  end
end

`endif

//--- test/tb_rtc_setter.sv
`timescale 1ns/1ps

module tb_rtc_setter;

  localparam int TIMEOUT_CYCLES = 4000; // six tests of up to 20 writes of 15 cycles plus margin

  localparam panel_bus_pkg::buttons_t UP    = '{up: 1'b1, default: 1'b0};
  localparam panel_bus_pkg::buttons_t DOWN  = '{down: 1'b1, default: 1'b0};
  localparam panel_bus_pkg::buttons_t LEFT  = '{left: 1'b1, default: 1'b0};
  localparam panel_bus_pkg::buttons_t RIGHT = '{right: 1'b1, default: 1'b0};

  logic                      clk;
  logic                      rst_n_i;
  panel_bus_pkg::buttons_t   btn_i;
  rtc_map_pkg::field_bytes_t fields_i;
  logic                      bus_req_o;
  panel_bus_pkg::wr_cmd_t    bus_cmd_o;
  logic                      bus_ack_i;
  logic                      init_done_o;

  rtc_setter_top #(.INIT_HOLD(12)) dut0 (.*);

  `include "tb_bus_model.svh"

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial
  begin : watchdog
    int cycles;
    for (cycles = 0; cycles < TIMEOUT_CYCLES; cycles++)
      @(posedge clk);
    $display("run timed out after %0d cycles before the tests finished", cycles);
    $display("CHECKS FAILED");
    $fatal(1, "timeout");
  end

  // drive and sample 10 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #10;
  endtask

  task automatic press(panel_bus_pkg::buttons_t b, int cycles = 1);
    step();
    btn_i = b;
    repeat (cycles) step();
    btn_i = '0;
  endtask

  task automatic apply_reset();
    rst_n_i = 1'b0;
    repeat (8) step();
    wr_log.delete();
    rst_n_i = 1'b1;
  endtask

  function automatic panel_bus_pkg::wr_cmd_t field_write(int k,
                                                         rtc_map_pkg::reg_data_t data);
    field_write.addr = 8'h21 + 8'(k); // field k sits at 0x21 + k
    field_write.data = data;
  endfunction

  // waits until write n is logged and the editor link has closed
  task automatic finish_write(int n);
    while (wr_log.size() <= n)
      step();
    while (dut0.u_edit.pending !== 1'b0)
      step();
  endtask

  task automatic edit_and_check(panel_bus_pkg::buttons_t b, panel_bus_pkg::wr_cmd_t exp);
    int n;
    n = wr_log.size();
    press(b);
    finish_write(n);
    check_count("write count", wr_log.size(), n + 1);
    check_cmd("bus_cmd_o", wr_log[n], exp);
  endtask

  task automatic test_init_sequence();
    check_bit("init_done_o", init_done_o, 1'b0);
    check_bit("bus_req_o", bus_req_o, 1'b0);
    press(UP); // editor still disabled
    press(RIGHT);
    while (init_done_o !== 1'b1)
      step();
    check_count("writes before init_done_o", wr_log.size(), 2);
    check_cmd("bus_cmd_o", wr_log[0], panel_bus_pkg::wr_cmd_t'(16'h0210));
    check_cmd("bus_cmd_o", wr_log[1], panel_bus_pkg::wr_cmd_t'(16'h0200));
    repeat (10) step();
    check_count("writes after init_done_o", wr_log.size(), 2);
  endtask

  task automatic test_up_down_wrap();
    fields_i = {$random(seed), $random(seed)};
    edit_and_check(UP, field_write(0, fields_i[0] + 8'd1));
    edit_and_check(DOWN, field_write(0, fields_i[0] - 8'd1));
    fields_i[0] = 8'hff;
    edit_and_check(UP, field_write(0, 8'h00));
    fields_i[0] = 8'h00;
    edit_and_check(DOWN, field_write(0, 8'hff));
  endtask

  task automatic test_cursor_walk();
    int k;
    int idx;
    for (k = 1; k <= 8; k++)
    begin
      idx = k % 8;
      press(RIGHT);
      edit_and_check(UP, field_write(idx, fields_i[3'(idx)] + 8'd1));
    end
    press(LEFT); // from field 0 back to the last field
    edit_and_check(UP, field_write(7, fields_i[7] + 8'd1));
    press(RIGHT);
  endtask

  task automatic test_hold_and_drop();
    int n;
    n = wr_log.size();
    press(UP, 40);
    finish_write(n);
    check_count("writes for a held button", wr_log.size(), n + 1);
    check_cmd("bus_cmd_o", wr_log[n], field_write(0, fields_i[0] + 8'd1));
    slow_extra = 20;
    press(DOWN);
    press(UP);    // dropped while the write is pending
    press(RIGHT);
    finish_write(n + 1);
    check_count("writes under slow acks", wr_log.size(), n + 2);
    check_cmd("bus_cmd_o", wr_log[n + 1], field_write(0, fields_i[0] - 8'd1));
    slow_extra = 0;
    edit_and_check(DOWN, field_write(0, fields_i[0] - 8'd1)); // cursor stayed on field 0
  endtask

  task automatic test_reset_mid_edit();
    press(RIGHT);
    press(RIGHT);
    press(UP);
    while (bus_req_o !== 1'b1)
      step();
    apply_reset();
    test_init_sequence();
    edit_and_check(UP, field_write(0, fields_i[0] + 8'd1));
  endtask

  initial
  begin
    rst_n_i  = 1'b0;
    btn_i    = '0;
    fields_i = '0;
    apply_reset();
    test_init_sequence();
    test_up_down_wrap();
    test_cursor_walk();
    test_hold_and_drop();
    test_reset_mid_edit();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- files.f
+incdir+test
verilog/rtc_map_pkg.sv
verilog/panel_bus_pkg.sv
verilog/button_pulse.sv
verilog/init_sequencer.sv
verilog/field_editor.sv
verilog/write_arbiter.sv
verilog/rtc_setter_top.sv
test/tb_rtc_setter.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rtc_setter
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
